// File: verilog.f
spi_pkg.sv
spi_shift_engine.sv
spi_cmd_ctrl.sv
spi_cmd_master.sv
tb_spi_slave_model.sv
tb_spi_cmd_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_spi_cmd_master \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST OK$" sim.log
then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// File: tb_spi_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_cmd_master;

  logic              clk;
  logic              rst_n;
  logic              cmd_req;
  spi_pkg::spi_cmd_t cmd;
  logic              miso;
  logic              cmd_ack;
  spi_pkg::spi_rsp_t rsp;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  logic              frame_err;
  int                gap_cycles;
  int                frame_cnt;
  int                win_cnt;

  logic [15:0] lfsr_state;
  logic [7:0]  shadow [8];
  int          wait_limit = 1000;
  int          checks;
  int          fails;
  int          tests;
  int          tests_failed;

  spi_cmd_master dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .miso    (miso),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi)
  );

  tb_spi_slave_model u_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .frame_err  (frame_err),
    .gap_cycles (gap_cycles),
    .frame_cnt  (frame_cnt),
    .win_cnt    (win_cnt)
  );

  initial clk = 1'b0;

  always #4 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 16'hB400;
    end
    else
    begin
      return s >> 1;
    end
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic spi_pkg::spi_cmd_t make_cmd(input spi_pkg::spi_op_e op,
                                                 input logic [2:0] addr,
                                                 input logic [7:0] data);
    spi_pkg::spi_cmd_t c;
    c.op   = op;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      fails++;
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("%0d tests, %0d failed, %0d checks, %0d check errors",
             tests, tests_failed, checks, fails);
    if (!timed_out && fails == 0 && tests_failed == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    finish_run(1'b1);
  endtask

  task automatic test_end(input string name, input int fails_before);
    tests++;
    if (fails == fails_before)
    begin
      $display("[%0d] %s: pass", tests, name);
    end
    else
    begin
      tests_failed++;
      $display("[%0d] %s: fail with %0d errors", tests, name, fails - fails_before);
    end
  endtask

  // full four-phase handshake with cmd_req held for hold cycles after ack
  task automatic do_cmd(input spi_pkg::spi_cmd_t c, input int hold,
                        output spi_pkg::spi_rsp_t r);
    int n;
    @(posedge clk);
    cmd     <= c;
    cmd_req <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!cmd_ack && n < wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ack)
    begin
      timeout_abort("cmd_ack never rose after cmd_req was raised");
    end
    else
    begin
      r = rsp;
      for (int i = 0; i < hold; i++)
      begin
        @(negedge clk);
        expect_eq("cmd_ack during hold", 32'(cmd_ack), 32'd1);
        expect_eq("rsp during hold", 32'(rsp.rdata), 32'(r.rdata));
        expect_eq("cs_n during hold", 32'(cs_n), 32'd1);
        expect_eq("sclk during hold", 32'(sclk), 32'd0);
      end
      @(posedge clk);
      cmd_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (cmd_ack && n < wait_limit)
      begin
        @(negedge clk);
        n++;
      end
      if (cmd_ack)
      begin
        timeout_abort("cmd_ack stayed high after cmd_req was dropped");
      end
      else
      begin
        expect_eq("slave frame error flag", 32'(frame_err), 32'd0);
      end
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    spi_pkg::spi_rsp_t r;
    do_cmd(make_cmd(spi_pkg::OP_WRITE, addr, data), 0, r);
    expect_eq("write rsp", 32'(r.rdata), 32'd0);
    shadow[addr] = data;
  endtask

  task automatic read_check(input logic [2:0] addr, input int hold);
    spi_pkg::spi_rsp_t r;
    do_cmd(make_cmd(spi_pkg::OP_READ, addr, 8'h00), hold, r);
    expect_eq($sformatf("read data at address %0d", addr), 32'(r.rdata), 32'(shadow[addr]));
  endtask

  task automatic test_reset_idle();
    int f0;
    f0 = fails;
    @(posedge clk);
    for (int i = 0; i < 60; i++)
    begin
      @(negedge clk);
      expect_eq("cs_n idle", 32'(cs_n), 32'd1);
      expect_eq("sclk idle", 32'(sclk), 32'd0);
      expect_eq("mosi idle", 32'(mosi), 32'd0);
      expect_eq("cmd_ack idle", 32'(cmd_ack), 32'd0);
      if (i == 9)
      begin
        @(posedge clk);
        rst_n <= 1'b1;
      end
    end
    test_end("reset idle", f0);
  endtask

  task automatic test_unwritten_regs();
    int f0;
    f0 = fails;
    for (int a = 0; a < 8; a++)
    begin
      read_check(3'(a), 0);
    end
    test_end("unwritten registers", f0);
  endtask

  task automatic test_write_read();
    logic [7:0] a;
    logic [7:0] d;
    int         f0;
    f0 = fails;
    draw_bits(3, a);
    draw_bits(8, d);
    write_reg(a[2:0], d);
    read_check(a[2:0], 0);
    test_end("write then read", f0);
  endtask

  task automatic test_register_sweep();
    logic [7:0] d;
    int         f0;
    f0 = fails;
    for (int a = 0; a < 8; a++)
    begin
      draw_bits(8, d);
      write_reg(3'(a), d);
    end
    for (int a = 0; a < 8; a++)
    begin
      read_check(3'(a), 0);
    end
    test_end("register sweep", f0);
  endtask

  task automatic test_frame_format();
    logic [7:0] a;
    logic [7:0] d;
    int         w0;
    int         fr0;
    int         f0;
    f0 = fails;
    draw_bits(3, a);
    draw_bits(8, d);
    w0  = win_cnt;
    fr0 = frame_cnt;
    write_reg(a[2:0], d);
    expect_eq("windows after write", 32'(win_cnt), 32'(w0 + 1));
    expect_eq("frames after write", 32'(frame_cnt), 32'(fr0 + 1));
    read_check(a[2:0], 0);
    expect_eq("windows after read", 32'(win_cnt), 32'(w0 + 3));
    expect_eq("frames after read", 32'(frame_cnt), 32'(fr0 + 2));
    expect_eq("read gap cycles", 32'(gap_cycles), 32'(spi_pkg::READ_GAP));
    expect_eq("frame error flag", 32'(frame_err), 32'd0);
    test_end("frame format", f0);
  endtask

  task automatic test_handshake_hold();
    logic [7:0] a;
    logic [7:0] d;
    int         f0;
    f0 = fails;
    draw_bits(3, a);
    read_check(a[2:0], 40);
    draw_bits(3, a);
    draw_bits(8, d);
    write_reg(a[2:0], d);
    read_check(a[2:0], 0);
    test_end("handshake hold", f0);
  endtask

  initial
  begin
    rst_n        <= 1'b0;
    cmd_req      <= 1'b0;
    cmd          <= '0;
    lfsr_state   = 16'd59825;
    checks       = 0;
    fails        = 0;
    tests        = 0;
    tests_failed = 0;
    for (int i = 0; i < 8; i++)
    begin
      shadow[i] = 8'hA0 + 8'(i);
    end
    test_reset_idle();
    test_unwritten_regs();
    test_write_read();
    test_register_sweep();
    test_frame_format();
    test_handshake_hold();
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// File: tb_spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave_model (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic frame_err,
  output int   gap_cycles,
  output int   frame_cnt,
  output int   win_cnt
);

  logic [7:0]  regs [8];
  logic [11:0] rx_sr;
  logic [7:0]  tx_sr;
  logic [2:0]  rd_addr;
  logic        rd_pending;
  logic        sclk_q;
  logic        cs_q;
  int          bits;

  // pins are sampled on clk, edges of sclk and cs_n show up one cycle late
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
      begin
        regs[i] <= 8'hA0 + 8'(i);
      end
      rx_sr      <= '0;
      tx_sr      <= '0;
      rd_addr    <= '0;
      rd_pending <= 1'b0;
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;
      bits       <= 0;
      miso       <= 1'b0;
      frame_err  <= 1'b0;
      gap_cycles <= 0;
      frame_cnt  <= 0;
      win_cnt    <= 0;
    end
    else
    begin
      sclk_q <= sclk;
      cs_q   <= cs_n;
      if (rd_pending && cs_n && cs_q)
      begin
        gap_cycles <= gap_cycles + 1;
      end
      if (cs_q && !cs_n)
      begin
        // window opens, the data window puts its first bit out at once
        bits  <= 0;
        rx_sr <= '0;
        if (rd_pending)
        begin
          miso  <= regs[rd_addr][7];
          tx_sr <= {regs[rd_addr][6:0], 1'b0};
        end
      end
      else if (!cs_n && !sclk_q && sclk)
      begin
        bits  <= bits + 1;
        rx_sr <= {rx_sr[10:0], mosi};
      end
      else if (!cs_n && sclk_q && !sclk && rd_pending)
      begin
        miso  <= tx_sr[7];
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
      else if (!cs_q && cs_n)
      begin
        win_cnt <= win_cnt + 1;
        miso    <= 1'b0;
        if (rd_pending)
        begin
          if (bits != 8)
          begin
            frame_err <= 1'b1;
          end
          rd_pending <= 1'b0;
          frame_cnt  <= frame_cnt + 1;
        end
        else if (bits == 12)
        begin
          if (!rx_sr[11])
          begin
            frame_err <= 1'b1;
          end
          else
          begin
            regs[rx_sr[10:8]] <= rx_sr[7:0];
          end
          frame_cnt <= frame_cnt + 1;
        end
        else if (bits == 4)
        begin
          if (rx_sr[3])
          begin
            frame_err <= 1'b1;
          end
          else
          begin
            rd_pending <= 1'b1;
            rd_addr    <= rx_sr[2:0];
            // this cycle already saw cs_n high
            gap_cycles <= 1;
          end
        end
        else
        begin
          frame_err <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: spi_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_master (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_req,
  input  spi_pkg::spi_cmd_t cmd,
  input  logic              miso,
  output logic              cmd_ack,
  output spi_pkg::spi_rsp_t rsp,
  output logic              sclk,
  output logic              cs_n,
  output logic              mosi
);

  logic                       start;
  logic                       busy;
  logic                       done;
  logic [spi_pkg::DATA_W-1:0] rx_byte;
  spi_pkg::shift_req_t        shift_req;

  // sequencing and cs_n
  spi_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .rx_byte   (rx_byte),
    .cmd_ack   (cmd_ack),
    .rsp       (rsp),
    .start     (start),
    .shift_req (shift_req),
    .cs_n      (cs_n)
  );

  // sclk generation and bit shifting
  spi_shift_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .shift_req (shift_req),
    .miso      (miso),
    .busy      (busy),
    .done      (done),
    .rx_byte   (rx_byte),
    .sclk      (sclk),
    .mosi      (mosi)
  );

endmodule

`default_nettype wire

// File: spi_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_req,
  input  spi_pkg::spi_cmd_t          cmd,
  input  logic                       busy,
  input  logic                       done,
  input  logic [spi_pkg::DATA_W-1:0] rx_byte,
  output logic                       cmd_ack,
  output spi_pkg::spi_rsp_t          rsp,
  output logic                       start,
  output spi_pkg::shift_req_t        shift_req,
  output logic                       cs_n
);

  spi_pkg::ctrl_state_e            state;
  spi_pkg::spi_cmd_t               cmd_q;
  logic [spi_pkg::GAP_CNT_W-1:0]   gap_cnt;
  logic                            issued;
  logic                            take;

  // new command only from IDLE with the previous ack already dropped
  assign take = (state == spi_pkg::IDLE) && cmd_req && !cmd_ack;

  // shift request follows the state, so it is valid while start is high
  always_comb
  begin
    case (state)
      spi_pkg::W_SHIFT:
      begin
        shift_req.tx_bits = cmd_q;
        shift_req.nbits   = spi_pkg::NBITS_CMD;
      end
      spi_pkg::R_HDR:
      begin
        shift_req.tx_bits = {cmd_q.op, cmd_q.addr, {spi_pkg::DATA_W{1'b0}}};
        shift_req.nbits   = spi_pkg::NBITS_HDR;
      end
      default:
      begin
        // read data window, mosi held low
        shift_req.tx_bits = '0;
        shift_req.nbits   = spi_pkg::NBITS_DATA;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= spi_pkg::IDLE;
      issued  <= 1'b0;
      gap_cnt <= '0;
      start   <= 1'b0;
      cs_n    <= 1'b1;
      cmd_ack <= 1'b0;
    end
    else
    begin
      start <= 1'b0;
      case (state)
        spi_pkg::IDLE:
        begin
          issued <= 1'b0;
          if (take)
          begin
            if (cmd.op == spi_pkg::OP_WRITE)
            begin
              state <= spi_pkg::W_SHIFT;
            end
            else
            begin
              state <= spi_pkg::R_HDR;
            end
          end
        end
        spi_pkg::W_SHIFT:
        begin
          if (!issued && !busy)
          begin
            start  <= 1'b1;
            cs_n   <= 1'b0;
            issued <= 1'b1;
          end
          else if (done)
          begin
            cs_n  <= 1'b1;
            state <= spi_pkg::ACK_HOLD;
          end
        end
        spi_pkg::R_HDR:
        begin
          if (!issued && !busy)
          begin
            start  <= 1'b1;
            cs_n   <= 1'b0;
            issued <= 1'b1;
          end
          else if (done)
          begin
            cs_n    <= 1'b1;
            gap_cnt <= '0;
            state   <= spi_pkg::R_GAP;
          end
        end
        spi_pkg::R_GAP:
        begin
          // cs_n high for exactly READ_GAP cycles, then straight into the data window
          if (gap_cnt == spi_pkg::GAP_LAST)
          begin
            start <= 1'b1;
            cs_n  <= 1'b0;
            state <= spi_pkg::R_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        spi_pkg::R_DATA:
        begin
          if (done)
          begin
            cs_n  <= 1'b1;
            state <= spi_pkg::ACK_HOLD;
          end
        end
        spi_pkg::ACK_HOLD:
        begin
          if (!cmd_ack)
          begin
            cmd_ack <= 1'b1;
          end
          else if (!cmd_req)
          begin
            cmd_ack <= 1'b0;
            state   <= spi_pkg::IDLE;
          end
        end
        default:
        begin
          state <= spi_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      cmd_q <= cmd;
      // writes answer with zero
      rsp   <= '0;
    end
    else if ((state == spi_pkg::R_DATA) && done)
    begin
      rsp.rdata <= rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  spi_pkg::shift_req_t        shift_req,
  input  logic                       miso,
  output logic                       busy,
  output logic                       done,
  output logic [spi_pkg::DATA_W-1:0] rx_byte,
  output logic                       sclk,
  output logic                       mosi
);

  logic [spi_pkg::HALF_CNT_W-1:0] half_cnt;
  logic [spi_pkg::NBITS_W-1:0]    bit_cnt;
  logic [spi_pkg::NBITS_W-1:0]    nbits_q;
  logic [spi_pkg::CMD_W-1:0]      tx_sr;
  logic [spi_pkg::DATA_W-1:0]     rx_sr;
  logic                           accept;
  logic                           half_end;
  logic                           rise_tick;
  logic                           last_bit;

  assign accept = start && !busy;

  // end of the current sclk half period
  assign half_end = busy && (half_cnt == spi_pkg::HALF_LAST);

  // sclk about to go high, mode 0 sample point
  assign rise_tick = half_end && !sclk;

  // bit_cnt counts rising edges already taken
  assign last_bit = (bit_cnt == nbits_q);

  assign mosi    = tx_sr[spi_pkg::CMD_W-1];
  assign rx_byte = rx_sr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      done     <= 1'b0;
      sclk     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      tx_sr    <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (!busy)
      begin
        if (start)
        begin
          busy     <= 1'b1;
          half_cnt <= '0;
          bit_cnt  <= '0;
          tx_sr    <= shift_req.tx_bits;
        end
      end
      else if (!half_end)
      begin
        half_cnt <= half_cnt + 1'b1;
      end
      else
      begin
        half_cnt <= '0;
        if (!sclk)
        begin
          sclk    <= 1'b1;
          bit_cnt <= bit_cnt + 1'b1;
        end
        else if (last_bit)
        begin
          // high phase of the final bit is over, close the window
          busy  <= 1'b0;
          done  <= 1'b1;
          sclk  <= 1'b0;
          tx_sr <= '0;
        end
        else
        begin
          // falling edge, next bit onto mosi
          sclk  <= 1'b0;
          tx_sr <= {tx_sr[spi_pkg::CMD_W-2:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      nbits_q <= shift_req.nbits;
    end
    if (rise_tick)
    begin
      rx_sr <= {rx_sr[spi_pkg::DATA_W-2:0], miso};
    end
  end

endmodule

`default_nettype wire

// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

  // frame geometry
  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;
  localparam int CMD_W  = 12;
  localparam int HDR_W  = 4;

  // sclk half period and read turnaround, in clk cycles
  localparam int SCLK_HALF = 4;
  localparam int READ_GAP  = 100;

  localparam int NBITS_W    = 4;
  localparam int HALF_CNT_W = $clog2(SCLK_HALF);
  localparam int GAP_CNT_W  = $clog2(READ_GAP);

  localparam logic [HALF_CNT_W-1:0] HALF_LAST = HALF_CNT_W'(SCLK_HALF - 1);
  localparam logic [GAP_CNT_W-1:0]  GAP_LAST  = GAP_CNT_W'(READ_GAP - 1);

  localparam logic [NBITS_W-1:0] NBITS_CMD  = NBITS_W'(CMD_W);
  localparam logic [NBITS_W-1:0] NBITS_HDR  = NBITS_W'(HDR_W);
  localparam logic [NBITS_W-1:0] NBITS_DATA = NBITS_W'(DATA_W);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  // field order matches the order on the wire, MSB first
  typedef struct packed {
    spi_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } spi_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } spi_rsp_t;

  // tx_bits is left aligned, only the top nbits are clocked out
  typedef struct packed {
    logic [CMD_W-1:0]   tx_bits;
    logic [NBITS_W-1:0] nbits;
  } shift_req_t;

  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    W_SHIFT  = 3'd1,
    R_HDR    = 3'd2,
    R_GAP    = 3'd3,
    R_DATA   = 3'd4,
    ACK_HOLD = 3'd5
  } ctrl_state_e;

endpackage

`default_nettype wire
